//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_video_top
OBJ_DIR   ?= obj_dir
FILELIST  ?= vlog.f
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= *** TEST PASSED ***

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- bus_regs.sv
// cpu accesses must be spaced three or more clocks apart and the xr address increments only after data writes
module bus_regs(
    input  logic          clk,
    input  logic          reset_i,
    input  logic          bus_cs_n_i,      // select strobe, active low
    input  logic          bus_rd_nwr_i,    // 1 = read, 0 = write
    input  logic [3:0]    bus_reg_num_i,
    input  logic          bus_bytesel_i,   // 0 = even (high) byte
    input  logic [7:0]    bus_data_i,
    output logic [7:0]    bus_data_o,
    input  xv_pkg::word_t xr_rd_data_i,    // video reg at current xr addr
    input  xv_pkg::intr_t intr_status_i,
    output logic          xr_wr_o,         // one clock write strobe
    output xv_pkg::word_t xr_addr_o,
    output xv_pkg::word_t xr_data_o,
    output xv_pkg::intr_t intr_mask_o,
    output xv_pkg::intr_t intr_clear_o     // one clock clear pulse
);

logic          cs_n_q;      // last select sample
logic          cs_edge;     // first low sample after high
logic          acc_q;       // access detected last clock
logic          rd_q;        // sampled bus fields
logic [3:0]    reg_q;
logic          byte_q;
logic [7:0]    data_q;
logic [7:0]    hold_hi;     // even byte parks here until the odd byte
logic          rd_pend;     // read word captured, byte goes out next
xv_pkg::word_t rd_word;
xv_pkg::word_t wr_word;

assign cs_edge = cs_n_q & ~bus_cs_n_i;
assign wr_word = {hold_hi, data_q};     // full word on odd byte write

// bus inputs taken on the detecting clock
always_ff @(posedge clk) begin
    if (cs_edge) begin
        rd_q   <= bus_rd_nwr_i;
        reg_q  <= bus_reg_num_i;
        byte_q <= bus_bytesel_i;
        data_q <= bus_data_i;
    end
    if (acc_q && !rd_q && byte_q) begin
        xr_data_o <= wr_word;           // only used when xr_wr_o follows
    end
    if (acc_q && rd_q) begin
        case (reg_q)
            xv_pkg::REG_XR_ADDR:    rd_word <= xr_addr_o;
            xv_pkg::REG_XR_DATA:    rd_word <= xr_rd_data_i;
            xv_pkg::REG_INTR_CTRL:  rd_word <= {4'h0, intr_mask_o, 4'h0, intr_status_i};
            xv_pkg::REG_INTR_CLEAR: rd_word <= {12'h000, intr_status_i};
            default:                rd_word <= '0;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        cs_n_q       <= 1'b1;       // no false edge out of reset
        acc_q        <= 1'b0;
        rd_pend      <= 1'b0;
        hold_hi      <= 8'h00;
        xr_wr_o      <= 1'b0;
        xr_addr_o    <= '0;
        intr_mask_o  <= '0;
        intr_clear_o <= '0;
        bus_data_o   <= 8'h00;
    end else begin
        cs_n_q       <= bus_cs_n_i;
        acc_q        <= cs_edge;
        rd_pend      <= acc_q & rd_q;
        xr_wr_o      <= 1'b0;           // strobes default low
        intr_clear_o <= '0;
        if (xr_wr_o) begin
            xr_addr_o <= xr_addr_o + 16'd1;     // step past the word just written
        end
        if (acc_q && !rd_q) begin
            if (!byte_q) begin
                hold_hi <= data_q;
            end else begin
                case (reg_q)
                    xv_pkg::REG_XR_ADDR:    xr_addr_o    <= wr_word;
                    xv_pkg::REG_XR_DATA:    xr_wr_o      <= 1'b1;
                    xv_pkg::REG_INTR_CTRL:  intr_mask_o  <= wr_word[3:0];
                    xv_pkg::REG_INTR_CLEAR: intr_clear_o <= wr_word[3:0];
                    default: ;
                endcase
            end
        end
        if (rd_pend) begin
            bus_data_o <= byte_q ? rd_word[7:0] : rd_word[15:8];   // held until next read
        end
    end
end

endmodule

//--- intr_ctrl.sv
// status records every source regardless of mask and the cpu pulse fires only on newly pending bits
module intr_ctrl(
    input  logic          clk,
    input  logic          reset_i,
    input  xv_pkg::intr_t intr_signal_i,   // one clock pulses per source
    input  xv_pkg::intr_t intr_mask_i,     // 1 = enabled
    input  xv_pkg::intr_t intr_clear_i,    // one clock clear pulses
    output xv_pkg::intr_t intr_status_o,   // pending bits
    output logic          bus_intr_o       // cpu strobe
);

xv_pkg::intr_t fresh;   // masked-in and not yet pending

assign fresh = intr_signal_i & intr_mask_i & ~intr_status_o;

always_ff @(posedge clk) begin
    if (reset_i) begin
        intr_status_o <= '0;
        bus_intr_o    <= 1'b0;
    end else begin
        bus_intr_o    <= |fresh;
        // clear beats a same-clock signal
        intr_status_o <= (intr_status_o | intr_signal_i) & ~intr_clear_i;
    end
end

endmodule

//--- palette_out.sv
// palette is write-only from the xr bus and its contents are undefined until loaded
module palette_out(
    input  logic               clk,
    input  logic               reset_i,
    input  logic               xr_wr_i,
    input  xv_pkg::word_t      xr_addr_i,
    input  xv_pkg::word_t      xr_data_i,
    input  xv_pkg::color_idx_t color_idx_i,
    input  logic               hsync_i,
    input  logic               vsync_i,
    input  logic               de_i,
    output logic [3:0]         red_o,
    output logic [3:0]         green_o,
    output logic [3:0]         blue_o,
    output logic               hsync_o,
    output logic               vsync_o,
    output logic               dv_de_o
);

localparam int DEPTH = 2 ** xv_pkg::COLOR_AWIDTH;

xv_pkg::word_t pal_mem [DEPTH];
xv_pkg::word_t pal_q;           // lookup, one clock behind the index
xv_pkg::rgb_t  rgb;
logic          pal_we;

// color region decode
assign pal_we = xr_wr_i && xr_addr_i[15] && (xr_addr_i[13:12] == xv_pkg::XR_COLOR_REGION);

always_ff @(posedge clk) begin
    if (pal_we) begin
        pal_mem[xr_addr_i[xv_pkg::COLOR_AWIDTH-1:0]] <= xr_data_i;
    end
    pal_q <= pal_mem[color_idx_i];   // sync read
end

// syncs follow the ram latency
always_ff @(posedge clk) begin
    if (reset_i) begin
        hsync_o <= 1'b0;
        vsync_o <= 1'b0;
        dv_de_o <= 1'b0;
    end else begin
        hsync_o <= hsync_i;
        vsync_o <= vsync_i;
        dv_de_o <= de_i;
    end
end

assign rgb     = dv_de_o ? pal_q[11:0] : '0;  // black in blanking
assign red_o   = rgb[11:8];
assign green_o = rgb[7:4];
assign blue_o  = rgb[3:0];

endmodule

//--- tb_video_top.sv
// assumes default timing parameters (28 x 14 clocks per frame) and bus accesses 3 clocks apart
module tb_video_top;

localparam int H_VISIBLE  = 16;
localparam int V_VISIBLE  = 8;
localparam int V_SYNC     = 2;
localparam int H_TOTAL    = 28;                       // 16 + 4 + 4 + 4
localparam int V_TOTAL    = 14;                       // 8 + 2 + 2 + 2
localparam int FRAME_CLKS = H_TOTAL * V_TOTAL;
localparam int BYTE_CLKS  = 5;                        // one byte access plus idle clocks
localparam int MAX_CYCLES = 16 + 600 * BYTE_CLKS + 14 * FRAME_CLKS;   // palette load + ~14 frames
localparam logic [31:0] SEED = 32'h7100_40b3;

logic        clk;
logic        reset_i;
logic        bus_cs_n_i;
logic        bus_rd_nwr_i;
logic [3:0]  bus_reg_num_i;
logic        bus_bytesel_i;
logic [7:0]  bus_data_i;
logic [7:0]  bus_data_o;
logic        bus_intr_o;
logic [3:0]  red_o;
logic [3:0]  green_o;
logic [3:0]  blue_o;
logic        hsync_o;
logic        vsync_o;
logic        dv_de_o;
logic [11:0] rgb;
logic [15:0] pal_model [256];                         // expected palette contents
int          errors = 0;
int          tests_run = 0;
int          tests_failed = 0;
int          intr_pulses = 0;                         // bus_intr_o high clocks seen
int          cycles;

assign rgb = {red_o, green_o, blue_o};

video_top dut_i(
    .clk(clk), .reset_i(reset_i),
    .bus_cs_n_i(bus_cs_n_i), .bus_rd_nwr_i(bus_rd_nwr_i), .bus_reg_num_i(bus_reg_num_i),
    .bus_bytesel_i(bus_bytesel_i), .bus_data_i(bus_data_i), .bus_data_o(bus_data_o),
    .bus_intr_o(bus_intr_o), .red_o(red_o), .green_o(green_o), .blue_o(blue_o),
    .hsync_o(hsync_o), .vsync_o(vsync_o), .dv_de_o(dv_de_o)
);

initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
end

always @(negedge clk) begin
    if (bus_intr_o) intr_pulses++;                    // one-clock pulses sampled mid-cycle
end

// watchdog
initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
        @(posedge clk);
        cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("*** TEST FAILED ***");
    $finish;
end

task automatic log_error(input string msg);
    $display("FAIL %0t: %s", $time, msg);
    errors++;
endtask

task automatic finish_test(input string name, input int err0);
    tests_run++;
    if (errors == err0) begin
        $display("%s: ok", name);
    end else begin
        $display("%s: %0d errors", name, errors - err0);
        tests_failed++;
    end
endtask

// single byte access, select low for one clock
task automatic bus_write(input logic [3:0] reg_num, input logic bytesel, input logic [7:0] data);
    @(negedge clk);
    bus_cs_n_i    = 1'b0;
    bus_rd_nwr_i  = 1'b0;
    bus_reg_num_i = reg_num;
    bus_bytesel_i = bytesel;
    bus_data_i    = data;
    @(negedge clk);
    bus_cs_n_i = 1'b1;
    repeat (3) @(negedge clk);                        // register updated by now
endtask

task automatic bus_read(input logic [3:0] reg_num, input logic bytesel, output logic [7:0] data);
    @(negedge clk);
    bus_cs_n_i    = 1'b0;
    bus_rd_nwr_i  = 1'b1;
    bus_reg_num_i = reg_num;
    bus_bytesel_i = bytesel;
    @(negedge clk);
    bus_cs_n_i = 1'b1;
    repeat (2) @(negedge clk);                        // valid 2 clocks after detection
    data = bus_data_o;
    @(negedge clk);
endtask

task automatic write_word(input logic [3:0] reg_num, input logic [15:0] word);
    bus_write(reg_num, 1'b0, word[15:8]);             // high byte parks first
    bus_write(reg_num, 1'b1, word[7:0]);              // commit
endtask

task automatic read_word(input logic [3:0] reg_num, output logic [15:0] word);
    bus_read(reg_num, 1'b0, word[15:8]);
    bus_read(reg_num, 1'b1, word[7:0]);
endtask

task automatic wait_vsync_start();
    @(negedge clk);
    while (vsync_o) @(negedge clk);
    while (!vsync_o) @(negedge clk);
endtask

task automatic wait_vsync_end();
    @(negedge clk);
    while (!vsync_o) @(negedge clk);
    while (vsync_o) @(negedge clk);
endtask

task automatic check_pulses(input string what, input int p0, input int want);
    repeat (4) @(negedge clk);                        // pulse lands within a few clocks
    if (intr_pulses - p0 != want) begin
        log_error($sformatf("%s: %0d interrupt pulses, expected %0d",
                            what, intr_pulses - p0, want));
    end
endtask

task automatic test_reset_frame();
    int   err0;
    int   de_clks;
    int   hs_rises;
    int   vs_rises;
    int   vs_clks;
    logic hs_prev;
    logic vs_prev;
    err0     = errors;
    de_clks  = 0;
    hs_rises = 0;
    vs_rises = 0;
    vs_clks  = 0;
    if (bus_intr_o !== 1'b0 || dv_de_o !== 1'b0 || rgb !== 12'h000) begin
        log_error("bus_intr_o, dv_de_o or rgb not low after reset");
    end
    wait_vsync_end();
    hs_prev = hsync_o;
    vs_prev = vsync_o;
    repeat (FRAME_CLKS) begin
        @(negedge clk);
        if (dv_de_o) de_clks++;
        if (vsync_o) vs_clks++;
        if (hsync_o && !hs_prev) hs_rises++;
        if (vsync_o && !vs_prev) vs_rises++;
        hs_prev = hsync_o;
        vs_prev = vsync_o;
    end
    if (de_clks != H_VISIBLE * V_VISIBLE) begin
        log_error($sformatf("%0d display enable clocks, expected %0d",
                            de_clks, H_VISIBLE * V_VISIBLE));
    end
    if (hs_rises != V_TOTAL) begin
        log_error($sformatf("%0d hsync edges, expected %0d", hs_rises, V_TOTAL));
    end
    if (vs_rises != 1 || vs_clks != V_SYNC * H_TOTAL) begin
        log_error($sformatf("%0d vsync edges over %0d clocks, expected 1 over %0d",
                            vs_rises, vs_clks, V_SYNC * H_TOTAL));
    end
    finish_test("reset_and_frame", err0);
endtask

task automatic test_palette();
    int          err0;
    int          pos;
    int          checked;
    logic [7:0]  base;
    logic [11:0] want;
    logic        de_prev;
    err0 = errors;
    write_word(xv_pkg::REG_XR_ADDR, 16'h8000);       // palette entry 0
    for (int i = 0; i < 256; i++) begin
        pal_model[i] = 16'($urandom);
        write_word(xv_pkg::REG_XR_DATA, pal_model[i]);    // address steps itself
    end
    base = 8'($urandom);
    write_word(xv_pkg::REG_XR_ADDR, 16'h0000);
    write_word(xv_pkg::REG_XR_DATA, {8'h00, base});
    wait_vsync_end();
    pos     = 0;
    checked = 0;
    de_prev = dv_de_o;
    repeat (FRAME_CLKS) begin
        @(negedge clk);
        if (dv_de_o && !de_prev) pos = 0;             // new line
        if (dv_de_o) begin
            want = pal_model[8'(base + pos)][11:0];
            if (rgb !== want) begin
                log_error($sformatf("pixel %0d rgb %h, expected %h", pos, rgb, want));
            end
            pos++;
            checked++;
        end else if (rgb !== 12'h000) begin
            log_error($sformatf("rgb %h in blanking", rgb));
        end
        de_prev = dv_de_o;
    end
    if (checked != H_VISIBLE * V_VISIBLE) begin
        log_error($sformatf("only %0d pixels seen", checked));
    end
    finish_test("palette_colors", err0);
endtask

task automatic test_video_regs();
    int          err0;
    logic [15:0] rd;
    err0 = errors;
    write_word(xv_pkg::REG_XR_ADDR, 16'h0000);
    write_word(xv_pkg::REG_XR_DATA, 16'h00a5);        // pix_base
    write_word(xv_pkg::REG_XR_DATA, 16'h003c);        // intr_line past the last line
    read_word(xv_pkg::REG_XR_ADDR, rd);
    if (rd !== 16'h0002) log_error($sformatf("xr address %h, expected 0002", rd));
    write_word(xv_pkg::REG_XR_ADDR, 16'h0000);
    read_word(xv_pkg::REG_XR_DATA, rd);
    if (rd !== 16'h00a5) log_error($sformatf("pix_base read %h, expected 00a5", rd));
    write_word(xv_pkg::REG_XR_ADDR, 16'h0001);
    read_word(xv_pkg::REG_XR_DATA, rd);
    if (rd !== 16'h003c) log_error($sformatf("intr_line read %h, expected 003c", rd));
    write_word(xv_pkg::REG_XR_ADDR, 16'h0002);
    read_word(xv_pkg::REG_XR_DATA, rd);
    if (rd !== 16'h0000) log_error($sformatf("signal reg read %h, expected 0000", rd));
    finish_test("video_regs", err0);
endtask

task automatic test_vsync_intr();
    int         err0;
    int         p0;
    logic [7:0] b;
    err0 = errors;
    wait_vsync_end();                                 // far from the next vsync
    write_word(xv_pkg::REG_INTR_CTRL, 16'h0002);
    write_word(xv_pkg::REG_INTR_CLEAR, 16'h0002);     // drop the bit set in earlier frames
    p0 = intr_pulses;
    wait_vsync_start();
    check_pulses("first vsync", p0, 1);
    bus_read(xv_pkg::REG_INTR_CTRL, 1'b0, b);
    if (b !== 8'h02) log_error($sformatf("mask read %h, expected 02", b));
    bus_read(xv_pkg::REG_INTR_CTRL, 1'b1, b);
    if (b[1] !== 1'b1) log_error($sformatf("status %h lacks vsync bit", b));
    wait_vsync_end();
    p0 = intr_pulses;
    wait_vsync_start();
    check_pulses("vsync while pending", p0, 0);
    wait_vsync_end();
    write_word(xv_pkg::REG_INTR_CLEAR, 16'h0002);
    p0 = intr_pulses;
    wait_vsync_start();
    check_pulses("vsync after clear", p0, 1);
    finish_test("vsync_interrupt", err0);
endtask

task automatic test_cpu_line_intr();
    int         err0;
    int         p0;
    int         n;
    logic [7:0] b;
    err0 = errors;
    write_word(xv_pkg::REG_INTR_CTRL, 16'h0004);
    write_word(xv_pkg::REG_INTR_CLEAR, 16'h000c);
    write_word(xv_pkg::REG_XR_ADDR, 16'h0002);
    p0 = intr_pulses;
    write_word(xv_pkg::REG_XR_DATA, 16'h0004);
    check_pulses("cpu signal bit 2", p0, 1);
    write_word(xv_pkg::REG_XR_ADDR, 16'h0002);        // address moved on after the write
    p0 = intr_pulses;
    write_word(xv_pkg::REG_XR_DATA, 16'h0008);
    check_pulses("cpu signal bit 3 masked out", p0, 0);
    bus_read(xv_pkg::REG_INTR_CTRL, 1'b1, b);
    if (b[3:2] !== 2'b11) log_error($sformatf("status %h lacks bits 2 and 3", b));
    write_word(xv_pkg::REG_XR_ADDR, 16'h0001);
    write_word(xv_pkg::REG_XR_DATA, 16'h0003);        // line 3
    write_word(xv_pkg::REG_INTR_CTRL, 16'h0001);
    p0 = intr_pulses;                                 // a line hit right after the clear counts
    write_word(xv_pkg::REG_INTR_CLEAR, 16'h0001);     // line bit pending since reset
    n  = 0;
    while (intr_pulses == p0 && n < FRAME_CLKS + 8) begin
        @(negedge clk);
        n++;
    end
    if (intr_pulses == p0) log_error("no line interrupt pulse within a frame");
    bus_read(xv_pkg::REG_INTR_CTRL, 1'b1, b);
    if (b[0] !== 1'b1) log_error($sformatf("status %h lacks line bit", b));
    finish_test("cpu_and_line_interrupt", err0);
endtask

initial begin
    reset_i       = 1'b1;
    bus_cs_n_i    = 1'b1;
    bus_rd_nwr_i  = 1'b1;
    bus_reg_num_i = 4'h0;
    bus_bytesel_i = 1'b0;
    bus_data_i    = 8'h00;
    void'($urandom(SEED));
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset_i = 1'b0;
    test_reset_frame();
    test_palette();
    test_video_regs();
    test_vsync_intr();
    test_cpu_line_intr();
    $display("tests run %0d, tests failed %0d, failed checks %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
        $display("*** TEST PASSED ***");
    end else begin
        $display("*** TEST FAILED ***");
    end
    $finish;
end

endmodule

//--- video_regs.sv
// only xr addresses with bit 15 clear land here and unknown register numbers read as zero
module video_regs(
    input  logic               clk,
    input  logic               reset_i,
    input  logic               xr_wr_i,
    input  xv_pkg::word_t      xr_addr_i,
    input  xv_pkg::word_t      xr_data_i,
    output xv_pkg::word_t      xr_rd_data_o,   // combinational from xr_addr_i
    output xv_pkg::color_idx_t pix_base_o,     // added to h count for the index
    output logic [7:0]         intr_line_o,    // line that raises the line interrupt
    output xv_pkg::intr_t      cpu_intr_o      // bits 3:2 only, one clock
);

logic vr_wr;

assign vr_wr = xr_wr_i && !xr_addr_i[15];

always_ff @(posedge clk) begin
    if (reset_i) begin
        pix_base_o  <= '0;
        intr_line_o <= 8'h00;
        cpu_intr_o  <= '0;
    end else begin
        cpu_intr_o <= '0;
        if (vr_wr) begin
            case (xr_addr_i[4:0])
                xv_pkg::VR_PIX_BASE:    pix_base_o  <= xr_data_i[7:0];
                xv_pkg::VR_INTR_LINE:   intr_line_o <= xr_data_i[7:0];
                xv_pkg::VR_INTR_SIGNAL: cpu_intr_o  <= {xr_data_i[3:2], 2'b00};  // nothing stored
                default: ;
            endcase
        end
    end
end

// read-back mux
always_comb begin
    xr_rd_data_o = '0;
    if (!xr_addr_i[15]) begin
        case (xr_addr_i[4:0])
            xv_pkg::VR_PIX_BASE:  xr_rd_data_o = {8'h00, pix_base_o};
            xv_pkg::VR_INTR_LINE: xr_rd_data_o = {8'h00, intr_line_o};
            default:              xr_rd_data_o = '0;   // signal reg reads as zero
        endcase
    end
end

endmodule

//--- video_timing.sv
// counters are 11 bits so each total must stay below 2048 and syncs are active high
module video_timing #(
    parameter int H_VISIBLE = 16,
    parameter int H_FRONT   = 4,
    parameter int H_SYNC    = 4,
    parameter int H_BACK    = 4,
    parameter int V_VISIBLE = 8,
    parameter int V_FRONT   = 2,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 2
) (
    input  logic               clk,
    input  logic               reset_i,
    input  xv_pkg::color_idx_t pix_base_i,
    input  logic [7:0]         intr_line_i,
    output logic               hsync_o,
    output logic               vsync_o,
    output logic               de_o,          // display enable
    output xv_pkg::color_idx_t color_idx_o,   // base plus h wrapping at 256
    output xv_pkg::intr_t      timing_intr_o  // line and vsync pulses
);

localparam int H_TOTAL      = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
localparam int V_TOTAL      = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
localparam int H_SYNC_START = H_VISIBLE + H_FRONT;
localparam int V_SYNC_START = V_VISIBLE + V_FRONT;

logic [10:0] h_cnt;
logic [10:0] v_cnt;
logic        h_end;     // last clock of the line

assign h_end = (h_cnt == 11'(H_TOTAL - 1));

// index registered beside de_o
always_ff @(posedge clk) begin
    color_idx_o <= pix_base_i + h_cnt[7:0];
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        h_cnt         <= '0;
        v_cnt         <= '0;
        hsync_o       <= 1'b0;
        vsync_o       <= 1'b0;
        de_o          <= 1'b0;
        timing_intr_o <= '0;
    end else begin
        hsync_o <= (h_cnt >= 11'(H_SYNC_START)) && (h_cnt < 11'(H_SYNC_START + H_SYNC));
        vsync_o <= (v_cnt >= 11'(V_SYNC_START)) && (v_cnt < 11'(V_SYNC_START + V_SYNC));
        de_o    <= (h_cnt < 11'(H_VISIBLE)) && (v_cnt < 11'(V_VISIBLE));
        timing_intr_o <= '0;
        timing_intr_o[xv_pkg::INTR_LINE_BIT]  <= (h_cnt == '0) && (v_cnt == {3'b000, intr_line_i});
        timing_intr_o[xv_pkg::INTR_VSYNC_BIT] <= (h_cnt == '0) && (v_cnt == 11'(V_SYNC_START));
        // visible, front, sync, back then wrap
        if (h_end) begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == 11'(V_TOTAL - 1)) ? '0 : v_cnt + 11'd1;
        end else begin
            h_cnt <= h_cnt + 11'd1;
        end
    end
end

endmodule

//--- video_top.sv
// pins lag the timing generator by one clock and palette reads are not reachable from the bus
module video_top #(
    parameter int H_VISIBLE = 16,
    parameter int H_FRONT   = 4,
    parameter int H_SYNC    = 4,
    parameter int H_BACK    = 4,
    parameter int V_VISIBLE = 8,
    parameter int V_FRONT   = 2,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 2
) (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       bus_cs_n_i,      // bus pins
    input  logic       bus_rd_nwr_i,
    input  logic [3:0] bus_reg_num_i,
    input  logic       bus_bytesel_i,
    input  logic [7:0] bus_data_i,
    output logic [7:0] bus_data_o,
    output logic       bus_intr_o,
    output logic [3:0] red_o,
    output logic [3:0] green_o,
    output logic [3:0] blue_o,
    output logic       hsync_o,
    output logic       vsync_o,
    output logic       dv_de_o
);

logic               xr_wr;           // xr write path, single master
xv_pkg::word_t      xr_addr;
xv_pkg::word_t      xr_data;
xv_pkg::word_t      xr_rd_data;
xv_pkg::intr_t      intr_mask;
xv_pkg::intr_t      intr_clear;
xv_pkg::intr_t      intr_status;
xv_pkg::intr_t      intr_signal;     // merged sources
xv_pkg::intr_t      timing_intr;
xv_pkg::intr_t      cpu_intr;
xv_pkg::color_idx_t pix_base;
logic [7:0]         intr_line;
xv_pkg::color_idx_t color_idx;
logic               hsync;           // raw timing, before palette stage
logic               vsync;
logic               de;

assign intr_signal = timing_intr | cpu_intr;   // disjoint bits

bus_regs regs_i(
    .clk(clk), .reset_i(reset_i),
    .bus_cs_n_i(bus_cs_n_i), .bus_rd_nwr_i(bus_rd_nwr_i), .bus_reg_num_i(bus_reg_num_i),
    .bus_bytesel_i(bus_bytesel_i), .bus_data_i(bus_data_i), .bus_data_o(bus_data_o),
    .xr_rd_data_i(xr_rd_data), .intr_status_i(intr_status),
    .xr_wr_o(xr_wr), .xr_addr_o(xr_addr), .xr_data_o(xr_data),
    .intr_mask_o(intr_mask), .intr_clear_o(intr_clear)
);

video_regs vregs_i(
    .clk(clk), .reset_i(reset_i),
    .xr_wr_i(xr_wr), .xr_addr_i(xr_addr), .xr_data_i(xr_data), .xr_rd_data_o(xr_rd_data),
    .pix_base_o(pix_base), .intr_line_o(intr_line), .cpu_intr_o(cpu_intr)
);

video_timing #(
    .H_VISIBLE(H_VISIBLE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_VISIBLE(V_VISIBLE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
) timing_i(
    .clk(clk), .reset_i(reset_i),
    .pix_base_i(pix_base), .intr_line_i(intr_line),
    .hsync_o(hsync), .vsync_o(vsync), .de_o(de),
    .color_idx_o(color_idx), .timing_intr_o(timing_intr)
);

palette_out palette_i(
    .clk(clk), .reset_i(reset_i),
    .xr_wr_i(xr_wr), .xr_addr_i(xr_addr), .xr_data_i(xr_data),
    .color_idx_i(color_idx), .hsync_i(hsync), .vsync_i(vsync), .de_i(de),
    .red_o(red_o), .green_o(green_o), .blue_o(blue_o),
    .hsync_o(hsync_o), .vsync_o(vsync_o), .dv_de_o(dv_de_o)
);

intr_ctrl intr_i(
    .clk(clk), .reset_i(reset_i),
    .intr_signal_i(intr_signal), .intr_mask_i(intr_mask), .intr_clear_i(intr_clear),
    .intr_status_o(intr_status), .bus_intr_o(bus_intr_o)
);

endmodule

//--- vlog.f
xv_pkg.sv
bus_regs.sv
video_regs.sv
video_timing.sv
palette_out.sv
intr_ctrl.sv
video_top.sv
tb_video_top.sv

//--- xv_pkg.sv
// shared widths and codes for the video controller; xr addresses are 16-bit words
package xv_pkg;

    typedef logic [15:0] word_t;         // xr data word and xr address
    typedef logic [7:0]  color_idx_t;    // palette index
    typedef logic [11:0] rgb_t;          // 4:4:4, red in the top nibble
    typedef logic [3:0]  intr_t;         // one bit per interrupt source

    localparam int COLOR_AWIDTH = 8;     // 256 palette entries

    // bus register numbers
    localparam logic [3:0] REG_XR_ADDR    = 4'd0;
    localparam logic [3:0] REG_XR_DATA    = 4'd1;
    localparam logic [3:0] REG_INTR_CTRL  = 4'd2;   // mask write, mask and status read
    localparam logic [3:0] REG_INTR_CLEAR = 4'd3;   // write 1s to drop pending bits

    // addr[13:12] region code, only meaningful with addr[15] set
    localparam logic [1:0] XR_COLOR_REGION = 2'b00;

    // video registers, addr[4:0] with addr[15] clear
    localparam logic [4:0] VR_PIX_BASE    = 5'd0;
    localparam logic [4:0] VR_INTR_LINE   = 5'd1;
    localparam logic [4:0] VR_INTR_SIGNAL = 5'd2;  // write-only strobe, reads as 0

    // timing interrupt positions
    // bits 2 and 3 come from cpu writes to VR_INTR_SIGNAL
    localparam int INTR_LINE_BIT  = 0;
    localparam int INTR_VSYNC_BIT = 1;

endpackage
